/* verilog/read_guard_settings.svh */
// Read guard build settings
// Slot count, field widths and counter prescaler for the AXI read guard

`ifndef READ_GUARD_SETTINGS_SVH
`define READ_GUARD_SETTINGS_SVH

// Number of read transactions tracked at once
`define GUARD_MAX_TXNS 4

// AXI field widths
`define GUARD_ID_WIDTH 4
`define GUARD_ADDR_WIDTH 32

// Budget and tick counter width, and clock cycles per tick
`define GUARD_CNT_WIDTH 16
`define GUARD_PRESCALE_DIV 4

`endif

/* verilog/axi_read_pkg.sv */
// AXI read-channel field types
// Shared by the guard blocks that look at AR and R traffic

`default_nettype none

`include "read_guard_settings.svh"

package axi_read_pkg;

  // Transaction ID on AR and R
  typedef logic [`GUARD_ID_WIDTH-1:0] id_t;

  // Read address
  typedef logic [`GUARD_ADDR_WIDTH-1:0] addr_t;

  // Burst length field, beats = len + 1
  typedef logic [7:0] len_t;

endpackage

`default_nettype wire

/* verilog/guard_pkg.sv */
// Read guard internal types
// Slot phase, fault causes and the per-transaction slot entry

`default_nettype none

`include "read_guard_settings.svh"

package guard_pkg;
  import axi_read_pkg::*;

  typedef logic [`GUARD_CNT_WIDTH-1:0] cnt_t;
  typedef logic [$clog2(`GUARD_MAX_TXNS)-1:0] slot_idx_t;

  // FREE must stay zero, a cleared entry is a free slot
  typedef enum logic [1:0] {
    FREE       = 2'd0,
    WAIT_FIRST = 2'd1,
    WAIT_LAST  = 2'd2
  } phase_t;

  typedef enum logic [1:0] {
    NONE            = 2'd0,
    FIRST_DATA_LATE = 2'd1,
    BURST_LATE      = 2'd2,
    UNEXPECTED_DATA = 2'd3
  } fault_cause_t;

  // One tracked read burst
  typedef struct packed {
    phase_t phase;
    id_t    id;
    addr_t  addr;
    len_t   len;
    cnt_t   first_budget;
    cnt_t   burst_budget;
    cnt_t   first_cnt;
    cnt_t   burst_cnt;
  } slot_entry_t;

endpackage

`default_nettype wire

/* verilog/guard_ifs.sv */
// Internal guard buses
// order_if links the tracker to its issue-order FIFO, fault_if carries the fault pulse

`default_nettype none

`include "read_guard_settings.svh"

interface order_if;
  import guard_pkg::*;

  logic      push;
  slot_idx_t push_idx;
  logic      pop;
  // Drops every queued index at once when the tracker flushes
  logic      flush;
  slot_idx_t head_idx;
  logic      empty;
  logic      full;

  modport fifo (
    input  push, push_idx, pop, flush,
    output head_idx, empty, full
  );

  modport tracker (
    output push, push_idx, pop, flush,
    input  head_idx, empty, full
  );
endinterface

interface fault_if;
  import guard_pkg::*;

  // One-cycle registered pulse with its record
  logic                         fault_valid;
  fault_cause_t                 fault_cause;
  logic [`GUARD_ID_WIDTH-1:0]   fault_id;
  logic [`GUARD_ADDR_WIDTH-1:0] fault_addr;

  modport source (output fault_valid, fault_cause, fault_id, fault_addr);
  modport sink (input fault_valid, fault_cause, fault_id, fault_addr);
endinterface

`default_nettype wire

/* verilog/order_fifo.sv */
// Issue-order FIFO
// Circular buffer of slot indices, oldest outstanding read burst at the head

`default_nettype none

`include "read_guard_settings.svh"

module order_fifo (
  input logic   clk_i,
  input logic   rst_ni,
  order_if.fifo order
);
  import guard_pkg::*;

  localparam int Depth = `GUARD_MAX_TXNS;
  localparam int CountW = $clog2(Depth + 1);
  localparam slot_idx_t LastPtr = slot_idx_t'(Depth - 1);

  slot_idx_t         mem_q [Depth];
  slot_idx_t         wr_ptr_q;
  slot_idx_t         rd_ptr_q;
  logic [CountW-1:0] count_q;

  assign order.head_idx = mem_q[rd_ptr_q];
  assign order.empty    = (count_q == '0);
  assign order.full     = (count_q == CountW'(Depth));

  always_ff @(posedge clk_i) begin
    if (order.push) begin
      mem_q[wr_ptr_q] <= order.push_idx;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (order.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (order.push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (order.pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({order.push, order.pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // The tracker only pushes with a slot to spare and pops a known head
  assert property (@(posedge clk_i) disable iff (!rst_ni) order.push |-> !order.full)
    else $error("order FIFO push while full");

  assert property (@(posedge clk_i) disable iff (!rst_ni) order.pop |-> !order.empty)
    else $error("order FIFO pop while empty");

endmodule

`default_nettype wire

/* verilog/txn_tracker.sv */
// Read transaction tracker
// Follows each AR burst through its data phase, runs the two latency budgets
// and checks R beats against the oldest outstanding burst

`default_nettype none

`include "read_guard_settings.svh"

module txn_tracker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ar_valid_i,
  input  logic                ar_ready_i,
  input  axi_read_pkg::id_t   ar_id_i,
  input  axi_read_pkg::addr_t ar_addr_i,
  input  axi_read_pkg::len_t  ar_len_i,
  input  logic                r_valid_i,
  input  logic                r_ready_i,
  input  axi_read_pkg::id_t   r_id_i,
  input  logic                r_last_i,
  input  guard_pkg::cnt_t     budget_unit_r_i,
  order_if.tracker            order,
  fault_if.source             fault
);
  import axi_read_pkg::*;
  import guard_pkg::*;

  localparam int Slots = `GUARD_MAX_TXNS;
  localparam int PreW = (`GUARD_PRESCALE_DIV > 1) ? $clog2(`GUARD_PRESCALE_DIV) : 1;

  slot_entry_t  slots_q [Slots];
  slot_entry_t  slots_d [Slots];
  logic [PreW-1:0] pre_q;
  logic         tick;

  logic         ar_hs;
  logic         all_live;
  slot_idx_t    free_idx;
  cnt_t         beats_live;
  cnt_t         beats_total;
  cnt_t         new_budget;

  // R beat stage, checked one cycle after the handshake
  logic         r_hs_q;
  id_t          r_id_q;
  logic         r_last_q;
  logic         unexpected;

  logic         fault_d;
  fault_cause_t cause_d;
  id_t          id_d;
  addr_t        addr_d;
  logic         fault_q;
  fault_cause_t cause_q;
  id_t          id_q;
  addr_t        addr_q;

  assign ar_hs = ar_valid_i && ar_ready_i;
  assign tick  = (pre_q == PreW'(`GUARD_PRESCALE_DIV - 1));

  // Lowest free slot and the beats still owed by live slots
  always_comb begin
    free_idx   = '0;
    all_live   = 1'b1;
    beats_live = '0;
    for (int i = Slots - 1; i >= 0; i--) begin
      if (slots_q[i].phase == FREE) begin
        free_idx = slot_idx_t'(i);
        all_live = 1'b0;
      end else begin
        beats_live = beats_live + cnt_t'(slots_q[i].len) + cnt_t'(1);
      end
    end
  end

  assign beats_total = beats_live + cnt_t'(ar_len_i) + cnt_t'(1);
  assign new_budget  = budget_unit_r_i * beats_total;

  assign unexpected = r_hs_q && (order.empty || (slots_q[order.head_idx].id != r_id_q));

  always_comb begin
    slots_d        = slots_q;
    order.push     = 1'b0;
    order.push_idx = free_idx;
    order.pop      = 1'b0;
    order.flush    = fault_q;

    if (tick) begin
      for (int i = 0; i < Slots; i++) begin
        if (slots_q[i].phase == WAIT_FIRST && slots_q[i].first_cnt != '1) begin
          slots_d[i].first_cnt = slots_q[i].first_cnt + 1'b1;
        end
        if (slots_q[i].phase == WAIT_LAST && slots_q[i].burst_cnt != '1) begin
          slots_d[i].burst_cnt = slots_q[i].burst_cnt + 1'b1;
        end
      end
    end

    // In-order beat for the head burst
    if (r_hs_q && !unexpected && !fault_q) begin
      if (r_last_q) begin
        slots_d[order.head_idx] = '0;
        order.pop = 1'b1;
      end else if (slots_q[order.head_idx].phase == WAIT_FIRST) begin
        slots_d[order.head_idx].phase = WAIT_LAST;
      end
    end

    if (ar_hs && !all_live && !fault_q) begin
      slots_d[free_idx] = '{
        phase:        WAIT_FIRST,
        id:           ar_id_i,
        addr:         ar_addr_i,
        len:          ar_len_i,
        first_budget: new_budget,
        burst_budget: new_budget,
        first_cnt:    '0,
        burst_cnt:    '0
      };
      order.push = 1'b1;
    end

    if (fault_q) begin
      for (int i = 0; i < Slots; i++) begin
        slots_d[i] = '0;
      end
    end
  end

  // Fault select, timeouts by lowest slot before a stray beat
  always_comb begin
    fault_d = 1'b0;
    cause_d = NONE;
    id_d    = '0;
    addr_d  = '0;
    if (unexpected) begin
      fault_d = 1'b1;
      cause_d = UNEXPECTED_DATA;
      id_d    = r_id_q;
    end
    for (int i = Slots - 1; i >= 0; i--) begin
      if ((slots_q[i].phase == WAIT_FIRST && slots_q[i].first_cnt > slots_q[i].first_budget) ||
          (slots_q[i].phase == WAIT_LAST && slots_q[i].burst_cnt > slots_q[i].burst_budget)) begin
        fault_d = 1'b1;
        cause_d = (slots_q[i].phase == WAIT_FIRST) ? FIRST_DATA_LATE : BURST_LATE;
        id_d    = slots_q[i].id;
        addr_d  = slots_q[i].addr;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Slots; i++) begin
        slots_q[i] <= '0;
      end
      pre_q   <= '0;
      r_hs_q  <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      slots_q <= slots_d;
      pre_q   <= tick ? '0 : pre_q + 1'b1;
      r_hs_q  <= r_valid_i && r_ready_i;
      // No second pulse while the flush is under way
      fault_q <= fault_d && !fault_q;
    end
  end

  always_ff @(posedge clk_i) begin
    r_id_q   <= r_id_i;
    r_last_q <= r_last_i;
    cause_q  <= cause_d;
    id_q     <= id_d;
    addr_q   <= addr_d;
  end

  assign fault.fault_valid = fault_q;
  assign fault.fault_cause = cause_q;
  assign fault.fault_id    = id_q;
  assign fault.fault_addr  = addr_q;

  // The guard gives no back-pressure, the master must not exceed the slot pool
  assert property (@(posedge clk_i) disable iff (!rst_ni) ar_hs |-> !all_live)
    else $error("AR handshake with all read slots live");

endmodule

`default_nettype wire

/* verilog/fault_reporter.sv */
// Fault reporter
// Keeps the first fault record and holds the interrupt and reset request
// until software pulses reset_clear_i

`default_nettype none

`include "read_guard_settings.svh"

module fault_reporter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  fault_if.sink                     fault,
  input  logic                      reset_clear_i,
  output logic                      irq_o,
  output logic                      reset_req_o,
  output guard_pkg::fault_cause_t   fault_cause_o,
  output axi_read_pkg::id_t         fault_id_o,
  output axi_read_pkg::addr_t       fault_addr_o
);
  import axi_read_pkg::*;
  import guard_pkg::*;

  logic         alarm_q;
  fault_cause_t cause_q;
  id_t          id_q;
  addr_t        addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alarm_q <= 1'b0;
      cause_q <= NONE;
      id_q    <= '0;
      addr_q  <= '0;
    end else if (fault.fault_valid && !alarm_q) begin
      // First fault wins, later ones are dropped until the clear
      alarm_q <= 1'b1;
      cause_q <= fault.fault_cause;
      id_q    <= fault.fault_id;
      addr_q  <= fault.fault_addr;
    end else if (reset_clear_i) begin
      alarm_q <= 1'b0;
      cause_q <= NONE;
      id_q    <= '0;
      addr_q  <= '0;
    end
  end

  // Both lines follow the same latched alarm
  assign irq_o         = alarm_q;
  assign reset_req_o   = alarm_q;
  assign fault_cause_o = cause_q;
  assign fault_id_o    = id_q;
  assign fault_addr_o  = addr_q;

  // A raised interrupt always carries a real cause from the tracker
  assert property (@(posedge clk_i) disable iff (!rst_ni) alarm_q |-> cause_q != NONE)
    else $error("interrupt raised with fault cause NONE");

endmodule

`default_nettype wire

/* verilog/read_guard.sv */
// AXI read-channel guard
// Passive monitor of AR and R traffic with latency budgets and response-order
// checks, raising an interrupt and a reset request on the first fault

`default_nettype none

module read_guard (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // AR channel
  input  logic                    ar_valid_i,
  input  logic                    ar_ready_i,
  input  axi_read_pkg::id_t       ar_id_i,
  input  axi_read_pkg::addr_t     ar_addr_i,
  input  axi_read_pkg::len_t      ar_len_i,
  // R channel
  input  logic                    r_valid_i,
  input  logic                    r_ready_i,
  input  axi_read_pkg::id_t       r_id_i,
  input  logic                    r_last_i,
  // Ticks allowed per outstanding beat
  input  guard_pkg::cnt_t         budget_unit_r_i,
  input  logic                    reset_clear_i,
  output logic                    irq_o,
  output logic                    reset_req_o,
  output guard_pkg::fault_cause_t fault_cause_o,
  output axi_read_pkg::id_t       fault_id_o,
  output axi_read_pkg::addr_t     fault_addr_o
);

  order_if order_bus ();
  fault_if fault_bus ();

  order_fifo u_order_fifo (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .order (order_bus)
  );

  txn_tracker u_txn_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_i     (ar_ready_i),
    .ar_id_i        (ar_id_i),
    .ar_addr_i      (ar_addr_i),
    .ar_len_i       (ar_len_i),
    .r_valid_i      (r_valid_i),
    .r_ready_i      (r_ready_i),
    .r_id_i         (r_id_i),
    .r_last_i       (r_last_i),
    .budget_unit_r_i(budget_unit_r_i),
    .order          (order_bus),
    .fault          (fault_bus)
  );

  fault_reporter u_fault_reporter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fault        (fault_bus),
    .reset_clear_i(reset_clear_i),
    .irq_o        (irq_o),
    .reset_req_o  (reset_req_o),
    .fault_cause_o(fault_cause_o),
    .fault_id_o   (fault_id_o),
    .fault_addr_o (fault_addr_o)
  );

endmodule

`default_nettype wire

/* verification/read_guard_checker.sv */
// Read guard checker
// Compares the guard's fault outputs with the expected record of each test
// and keeps the pass and fail counts

`default_nettype none

module read_guard_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    irq_i,
  input  logic                    reset_req_i,
  input  guard_pkg::fault_cause_t fault_cause_i,
  input  axi_read_pkg::id_t       fault_id_i,
  input  axi_read_pkg::addr_t     fault_addr_i,
  input  logic                    check_i,
  input  logic                    test_end_i,
  input  logic                    stray_beat_i,
  input  int                      test_num_i,
  input  guard_pkg::fault_cause_t exp_cause_i,
  input  axi_read_pkg::id_t       exp_id_i,
  input  axi_read_pkg::addr_t     exp_addr_i,
  input  logic                    exp_alarm_i,
  output int                      pass_count_o,
  output int                      fail_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int test_errs = 0;
  int passes = 0;
  int fails = 0;
  // Edges seen since a stray R beat was sampled (zero when idle)
  int beat_age = 0;

  assign pass_count_o = passes;
  assign fail_count_o = fails;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR test %0d: %s = 0x%0h, expected 0x%0h", test_num_i, name, got, exp);
      test_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Stray beat sampled at edge N raises the alarm only after edge N+2
      if (beat_age == 2) begin
        compare("irq_o", 32'(irq_i), 32'h0);
      end
      if (beat_age == 3) begin
        compare("irq_o", 32'(irq_i), 32'h1);
      end
      if (stray_beat_i) begin
        beat_age = 1;
      end else if (beat_age > 0 && beat_age < 3) begin
        beat_age++;
      end else begin
        beat_age = 0;
      end

      if (check_i) begin
        compare("fault_cause_o", 32'(fault_cause_i), 32'(exp_cause_i));
        compare("fault_id_o", 32'(fault_id_i), 32'(exp_id_i));
        compare("fault_addr_o", 32'(fault_addr_i), 32'(exp_addr_i));
        compare("irq_o", 32'(irq_i), 32'(exp_alarm_i));
        compare("reset_req_o", 32'(reset_req_i), 32'(exp_alarm_i));
      end

      if (test_end_i) begin
        if (test_errs == 0) begin
          passes++;
          $display("test %0d passed", test_num_i);
        end else begin
          fails++;
          $display("test %0d failed with %0d mismatches", test_num_i, test_errs);
        end
        test_errs = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/tb_read_guard.sv */
// Read guard testbench
// Replays the golden test records against the guard and hands the
// expected results to the checker

`default_nettype none

`include "read_guard_settings.svh"

module tb_read_guard;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_read_pkg::*;
  import guard_pkg::*;

  localparam int NumTests = 7;
  localparam int RecWords = 18;
  localparam int HoldCycles = 8;
  localparam int SettleCycles = 6;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         ar_valid_i;
  logic         ar_ready_i;
  id_t          ar_id_i;
  addr_t        ar_addr_i;
  len_t         ar_len_i;
  logic         r_valid_i;
  logic         r_ready_i;
  id_t          r_id_i;
  logic         r_last_i;
  cnt_t         budget_unit_r_i;
  logic         reset_clear_i;
  logic         irq_o;
  logic         reset_req_o;
  fault_cause_t fault_cause_o;
  id_t          fault_id_o;
  addr_t        fault_addr_o;

  logic         check_stb;
  logic         end_stb;
  logic         stray_beat;
  int           test_num;
  fault_cause_t exp_cause;
  id_t          exp_id;
  addr_t        exp_addr;
  logic         exp_alarm;
  int           passes;
  int           fails;
  int           limit_cycles = 0;
  integer       seed;
  logic [31:0]  golden [NumTests * RecWords];

  always #2 clk_i = ~clk_i;

  read_guard dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_i     (ar_ready_i),
    .ar_id_i        (ar_id_i),
    .ar_addr_i      (ar_addr_i),
    .ar_len_i       (ar_len_i),
    .r_valid_i      (r_valid_i),
    .r_ready_i      (r_ready_i),
    .r_id_i         (r_id_i),
    .r_last_i       (r_last_i),
    .budget_unit_r_i(budget_unit_r_i),
    .reset_clear_i  (reset_clear_i),
    .irq_o          (irq_o),
    .reset_req_o    (reset_req_o),
    .fault_cause_o  (fault_cause_o),
    .fault_id_o     (fault_id_o),
    .fault_addr_o   (fault_addr_o)
  );

  read_guard_checker chk0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_o),
    .reset_req_i  (reset_req_o),
    .fault_cause_i(fault_cause_o),
    .fault_id_i   (fault_id_o),
    .fault_addr_i (fault_addr_o),
    .check_i      (check_stb),
    .test_end_i   (end_stb),
    .stray_beat_i (stray_beat),
    .test_num_i   (test_num),
    .exp_cause_i  (exp_cause),
    .exp_id_i     (exp_id),
    .exp_addr_i   (exp_addr),
    .exp_alarm_i  (exp_alarm),
    .pass_count_o (passes),
    .fail_count_o (fails)
  );

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  function automatic logic [31:0] rec_word(input int t, input int f);
    return golden[t * RecWords + f];
  endfunction

  task automatic issue_bursts(input int t);
    budget_unit_r_i = cnt_t'(rec_word(t, 1));
    for (int b = 0; b < int'(rec_word(t, 0)); b++) begin
      ar_valid_i = 1'b1;
      ar_ready_i = 1'b1;
      ar_id_i    = id_t'(rec_word(t, 9 + 3 * b));
      ar_addr_i  = addr_t'(rec_word(t, 10 + 3 * b));
      ar_len_i   = len_t'(rec_word(t, 11 + 3 * b));
      step();
    end
    ar_valid_i = 1'b0;
    ar_ready_i = 1'b0;
  endtask

  // Data in issue order, each burst after its delay in prescaler ticks
  task automatic answer_bursts(input int t);
    int   beats;
    id_t  id;
    logic wrong;
    logic withhold;
    wrong    = (rec_word(t, 3) != 0);
    withhold = (rec_word(t, 4) != 0);
    for (int b = 0; b < int'(rec_word(t, 0)); b++) begin
      id    = id_t'(rec_word(t, 9 + 3 * b));
      beats = int'(rec_word(t, 11 + 3 * b)) + 1;
      idle(int'(rec_word(t, 2)) * `GUARD_PRESCALE_DIV);
      for (int k = 0; k < beats; k++) begin
        // A withheld last beat ends the data of the test
        if (withhold && k == beats - 1) begin
          return;
        end
        r_valid_i  = 1'b1;
        r_ready_i  = 1'b1;
        r_id_i     = wrong ? ~id : id;
        r_last_i   = (k == beats - 1);
        stray_beat = wrong;
        step();
        r_valid_i  = 1'b0;
        r_ready_i  = 1'b0;
        r_last_i   = 1'b0;
        stray_beat = 1'b0;
        if (wrong) begin
          return;
        end
      end
    end
  endtask

  task automatic wait_for_irq(input int t);
    int waited;
    waited = 0;
    while (!irq_o && waited < int'(rec_word(t, 8))) begin
      step();
      waited++;
    end
    if (!irq_o) begin
      $display("Test %0d: irq_o stayed low for %0d cycles after the stimulus", t + 1, waited);
    end
  endtask

  task automatic check_outputs(
    input fault_cause_t cause,
    input id_t          id,
    input addr_t        addr,
    input logic         alarm
  );
    exp_cause = cause;
    exp_id    = id;
    exp_addr  = addr;
    exp_alarm = alarm;
    check_stb = 1'b1;
    step();
    check_stb = 1'b0;
  endtask

  task automatic pulse_clear();
    reset_clear_i = 1'b1;
    step();
    reset_clear_i = 1'b0;
  endtask

  task automatic run_test(input int t);
    logic [31:0] cause_word;
    cause_word = rec_word(t, 5);
    if (cause_word == 0) begin
      idle({$random(seed)} % 4);
    end
    issue_bursts(t);
    answer_bursts(t);
    if (cause_word == 0) begin
      idle(SettleCycles);
      check_outputs(NONE, '0, '0, 1'b0);
    end else begin
      wait_for_irq(t);
      // Alarm must hold across idle cycles until the clear
      idle(HoldCycles);
      check_outputs(fault_cause_t'(cause_word[1:0]), id_t'(rec_word(t, 6)),
                    addr_t'(rec_word(t, 7)), 1'b1);
      pulse_clear();
      idle(2);
      check_outputs(NONE, '0, '0, 1'b0);
    end
    end_stb = 1'b1;
    step();
    end_stb = 1'b0;
  endtask

  initial begin
    int sum_cycles;
    seed            = 32'hd338;
    rst_ni          = 1'b0;
    ar_valid_i      = 1'b0;
    ar_ready_i      = 1'b0;
    ar_id_i         = '0;
    ar_addr_i       = '0;
    ar_len_i        = '0;
    r_valid_i       = 1'b0;
    r_ready_i       = 1'b0;
    r_id_i          = '0;
    r_last_i        = 1'b0;
    budget_unit_r_i = '0;
    reset_clear_i   = 1'b0;
    check_stb       = 1'b0;
    end_stb         = 1'b0;
    stray_beat      = 1'b0;
    test_num        = 0;
    exp_cause       = NONE;
    exp_id          = '0;
    exp_addr        = '0;
    exp_alarm       = 1'b0;
    $readmemh("verification/read_guard_golden.txt", golden);
    sum_cycles = 0;
    for (int t = 0; t < NumTests; t++) begin
      sum_cycles += int'(rec_word(t, 8));
    end
    limit_cycles = 2 * sum_cycles;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    step();
    for (int t = 0; t < NumTests; t++) begin
      test_num = t + 1;
      run_test(t);
    end
    $display("%0d tests run, %0d passed, %0d failed", NumTests, passes, fails);
    if (fails == 0 && passes == NumTests) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the cycle lengths in the golden file
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/read_guard_golden.txt */
// Line 1: bursts budget_unit delay_ticks wrong_id withhold_last exp_cause exp_id exp_addr cycles
// Line 2: id addr len for bursts 0 to 2, unused bursts are zero
// 1: three in-order bursts answered well inside budget
3 4 1 0 0 0 0 00000000 50
3 00001000 1  5 00002040 3  3 00003000 0
// 2: first beat carries an ID that is not the oldest outstanding one
2 8 1 1 0 3 D 00000000 40
2 40000000 1  6 40000100 0  0 00000000 0
// 3: single burst that never gets data
1 1 0 0 1 1 9 00008000 40
9 00008000 0  0 00000000 0  0 00000000 0
// 4: first beats arrive, last beat withheld
1 1 1 0 1 2 C 12345678 50
C 12345678 2  0 00000000 0  0 00000000 0
// 5: queued burst waits past its own share but inside the shared budget
2 2 3 0 0 0 0 00000000 80
1 00002000 3  2 00002100 0  0 00000000 0
// 6: stray beat with three bursts live, the flush must free all of them
3 8 0 1 0 3 E 00000000 40
1 0000A000 0  2 0000A040 1  3 0000A080 2
// 7: three good bursts right after the flush
3 4 1 0 0 0 0 00000000 60
4 0000B000 1  5 0000B100 0  7 0000B200 3

/* list.f */
+incdir+verilog
verilog/axi_read_pkg.sv
verilog/guard_pkg.sv
verilog/guard_ifs.sv
verilog/order_fifo.sv
verilog/txn_tracker.sv
verilog/fault_reporter.sv
verilog/read_guard.sv
verification/read_guard_checker.sv
verification/tb_read_guard.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_read_guard
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
